/* Makefile */
# Verilator build and run of the stream write master testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_stream_write_master
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* hdl/axi_stream_write_master.sv */
////////////////////////////////////////
// Stream to AXI4 burst write master
// Sequencer plus AW, W and B channels
////////////////////////////////////////
`default_nettype none

module axi_stream_write_master import axi_write_pkg::*; #(
  parameter int max_burst_len = 16,
  parameter int max_outstanding = 4
) (
  input  logic              aclk,
  input  logic              areset,
  // Control, sampled on ctrl_start
  input  logic              ctrl_start,
  output logic              ctrl_done,
  input  logic [addr_w-1:0] ctrl_addr_offset,
  input  logic [xfer_w-1:0] ctrl_xfer_size_in_bytes,
  // AXI4 write side
  output logic              m_axi_awvalid,
  input  logic              m_axi_awready,
  output logic [addr_w-1:0] m_axi_awaddr,
  output logic [7:0]        m_axi_awlen,
  output logic              m_axi_wvalid,
  input  logic              m_axi_wready,
  output logic [data_w-1:0] m_axi_wdata,
  output logic [strb_w-1:0] m_axi_wstrb,
  output logic              m_axi_wlast,
  input  logic              m_axi_bvalid,
  output logic              m_axi_bready,
  // Data stream in
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  logic [data_w-1:0] s_axis_tdata
);

  localparam int burst_len = burst_beats_of(max_burst_len);
  localparam int log_burst_len = $clog2(burst_len);

  logic                             load;
  logic                             running;
  logic [addr_w-1:0]                start_addr;
  logic [beats_w-log_burst_len-1:0] num_bursts;
  logic [log_burst_len-1:0]         final_burst_len;
  logic [strb_w-1:0]                final_strb;
  logic                             burst_first;
  logic                             beat_done;
  logic                             credit_empty;
  logic                             last_resp;
  logic                             aw_accept;

  transfer_sequencer #(.log_burst_len(log_burst_len)) u_seq (
    .aclk (aclk), .areset (areset),
    .ctrl_start (ctrl_start), .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .beat_done (beat_done), .last_resp (last_resp),
    .ctrl_done (ctrl_done), .running (running), .load (load),
    .start_addr (start_addr), .num_bursts (num_bursts),
    .final_burst_len (final_burst_len), .final_strb (final_strb)
  );

  write_data_channel #(.log_burst_len(log_burst_len)) u_w (
    .aclk (aclk), .areset (areset), .running (running), .load (load),
    .num_bursts (num_bursts), .final_burst_len (final_burst_len),
    .final_strb (final_strb),
    .s_axis_tvalid (s_axis_tvalid), .s_axis_tready (s_axis_tready),
    .s_axis_tdata (s_axis_tdata),
    .m_axi_wvalid (m_axi_wvalid), .m_axi_wready (m_axi_wready),
    .m_axi_wdata (m_axi_wdata), .m_axi_wstrb (m_axi_wstrb),
    .m_axi_wlast (m_axi_wlast),
    .burst_first (burst_first), .beat_done (beat_done)
  );

  write_address_channel #(
    .log_burst_len (log_burst_len),
    .burst_len     (burst_len)
  ) u_aw (
    .aclk (aclk), .areset (areset), .load (load),
    .start_addr (start_addr), .num_bursts (num_bursts),
    .final_burst_len (final_burst_len),
    .burst_first (burst_first), .credit_empty (credit_empty),
    .m_axi_awvalid (m_axi_awvalid), .m_axi_awready (m_axi_awready),
    .m_axi_awaddr (m_axi_awaddr), .m_axi_awlen (m_axi_awlen),
    .aw_accept (aw_accept)
  );

  write_response_channel #(
    .max_outstanding (max_outstanding),
    .log_burst_len   (log_burst_len)
  ) u_b (
    .aclk (aclk), .areset (areset), .load (load),
    .num_bursts (num_bursts), .aw_accept (aw_accept),
    .m_axi_bvalid (m_axi_bvalid), .m_axi_bready (m_axi_bready),
    .credit_empty (credit_empty), .last_resp (last_resp)
  );

endmodule

`default_nettype wire

/* hdl/axi_write_pkg.sv */
////////////////////////////////////////
// Bus widths and the 4 KiB burst limit
// Burst-length clamp function
// Byte-count union, raw or beats view
////////////////////////////////////////
`default_nettype none

package axi_write_pkg;

  // Memory address and data beat widths
  parameter int addr_w = 32;
  parameter int data_w = 64;

  // Bytes per beat and byte-offset bits within a beat
  parameter int strb_w = data_w / 8;
  parameter int log_strb_w = $clog2(strb_w);

  // Byte count width, and the beat count it holds
  parameter int xfer_w = 20;
  parameter int beats_w = xfer_w - log_strb_w;

  // AXI4 bursts never exceed or cross a 4 KiB page
  parameter int max_burst_bytes = 4096;

  // Clamp a requested burst length to what fits in one page
  function automatic int burst_beats_of(input int max_len);
    int page_beats;
    page_beats = max_burst_bytes / strb_w;
    return (max_len < page_beats) ? max_len : page_beats;
  endfunction

  // Byte count split into whole beats plus leftover bytes
  typedef struct packed {
    logic [beats_w-1:0]    beats;
    logic [log_strb_w-1:0] rem;
  } xfer_split_t;

  // Same word seen as raw bytes or as beats and remainder
  typedef union packed {
    logic [xfer_w-1:0] bytes;
    xfer_split_t       split;
  } xfer_size_u;

endpackage

`default_nettype wire

/* hdl/transfer_sequencer.sv */
////////////////////////////////////////
// Transfer FSM, request capture
// Burst split, final strobe, done pulse
////////////////////////////////////////
`default_nettype none

module transfer_sequencer import axi_write_pkg::*; #(
  parameter int log_burst_len = 4
) (
  input  logic                             aclk,
  input  logic                             areset,
  input  logic                             ctrl_start,
  input  logic [addr_w-1:0]                ctrl_addr_offset,
  input  xfer_size_u                       ctrl_xfer_size_in_bytes,
  input  logic                             beat_done,
  input  logic                             last_resp,
  output logic                             ctrl_done,
  output logic                             running,
  output logic                             load,
  output logic [addr_w-1:0]                start_addr,
  output logic [beats_w-log_burst_len-1:0] num_bursts,
  output logic [log_burst_len-1:0]         final_burst_len,
  output logic [strb_w-1:0]                final_strb
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_setup = 2'd1;
  localparam logic [1:0] st_issue = 2'd2;
  localparam logic [1:0] st_wait_resp = 2'd3;

  // Low address bits inside one full burst
  localparam logic [addr_w-1:0] burst_mask = addr_w'((1 << (log_burst_len + log_strb_w)) - 1);

  logic [1:0]         state;
  xfer_size_u         xfer_r;
  // Beat count minus one, the AXI length format
  logic [beats_w-1:0] total_len_r;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= st_idle;
      load <= 1'b0;
      running <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      load <= 1'b0;
      ctrl_done <= 1'b0;
      case (state)
        // Start pulses outside idle are dropped
        st_idle: if (ctrl_start) state <= st_setup;
        st_setup: begin
          load <= 1'b1;
          state <= st_issue;
        end
        st_issue: begin
          // Open the stream the cycle after the channels load
          if (load) begin
            running <= 1'b1;
          end else if (beat_done) begin
            running <= 1'b0;
            state <= st_wait_resp;
          end
        end
        default: begin
          if (last_resp) begin
            ctrl_done <= 1'b1;
            state <= st_idle;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Request capture and decode
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (state == st_idle && ctrl_start) begin
      xfer_r <= ctrl_xfer_size_in_bytes;
      // Align down to a burst boundary
      start_addr <= ctrl_addr_offset & ~burst_mask;
    end
    if (state == st_setup) begin
      // Round up to whole beats, then subtract one
      total_len_r <= (xfer_r.split.rem != '0) ? xfer_r.split.beats
                                               : xfer_r.split.beats - 1'b1;
      // Low rem bytes on the last beat, all of them when rem is zero
      for (int i = 0; i < strb_w; i++) begin
        final_strb[i] <= (xfer_r.split.rem == '0) || (i < xfer_r.split.rem);
      end
    end
  end

  // Upper bits count full bursts, lower bits give the last length
  assign num_bursts = total_len_r[beats_w-1:log_burst_len];
  assign final_burst_len = total_len_r[log_burst_len-1:0];

  a_nonzero_size : assert property (
    @(posedge aclk) disable iff (areset)
    (ctrl_start && state == st_idle) |-> ctrl_xfer_size_in_bytes.bytes != '0
  );

endmodule

`default_nettype wire

/* hdl/up_down_counter.sv */
////////////////////////////////////////
// Loadable up/down counter
// with a zero flag
////////////////////////////////////////
`default_nettype none

module up_down_counter #(
  parameter int width = 8,
  parameter logic [width-1:0] init = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init;
    end else if (load) begin
      // Load beats any step request
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
    // incr with decr cancels out
  end

  assign is_zero = (count == '0);

  // Every user stops stepping down at zero, or reloads there
  // An underflow means the surrounding handshake bookkeeping is off
  a_no_underflow : assert property (
    @(posedge aclk) disable iff (areset)
    (decr && !incr && !load) |-> !is_zero
  );

endmodule

`default_nettype wire

/* hdl/write_address_channel.sv */
////////////////////////////////////////
// AW issue after data, under credit
// Burst address step and awlen
////////////////////////////////////////
`default_nettype none

module write_address_channel import axi_write_pkg::*; #(
  parameter int log_burst_len = 4,
  parameter int burst_len = 16
) (
  input  logic                             aclk,
  input  logic                             areset,
  input  logic                             load,
  input  logic [addr_w-1:0]                start_addr,
  input  logic [beats_w-log_burst_len-1:0] num_bursts,
  input  logic [log_burst_len-1:0]         final_burst_len,
  input  logic                             burst_first,
  input  logic                             credit_empty,
  output logic                             m_axi_awvalid,
  input  logic                             m_axi_awready,
  output logic [addr_w-1:0]                m_axi_awaddr,
  output logic [7:0]                       m_axi_awlen,
  output logic                             aw_accept
);

  localparam int nb_w = beats_w - log_burst_len;
  // Data may run ahead by a whole transfer
  localparam int pend_w = nb_w + 1;
  localparam logic [addr_w-1:0] burst_bytes = addr_w'(burst_len * strb_w);

  logic              no_pending;
  logic              final_aw;
  logic              awvalid_r;
  logic [addr_w-1:0] addr_r;

  assign aw_accept = awvalid_r & m_axi_awready;
  assign m_axi_awvalid = awvalid_r;
  assign m_axi_awaddr = addr_r;
  // Full length except on the last burst
  assign m_axi_awlen = final_aw ? 8'(final_burst_len) : 8'(burst_len - 1);

  // Bursts whose data showed up but whose address is not out yet
  up_down_counter #(
    .width (pend_w),
    .init  ('0)
  ) u_pending_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_first),
    .decr       (aw_accept),
    .load_value ('0),
    .count      (),
    .is_zero    (no_pending)
  );

  // Addresses still to issue after the current one
  up_down_counter #(
    .width (nb_w),
    .init  ('0)
  ) u_issue_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load),
    .incr       (1'b0),
    .decr       (aw_accept & ~final_aw),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (final_aw)
  );

  ////////////////////////////////////////
  // AW valid and address
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid_r <= 1'b0;
    end else if (!awvalid_r) begin
      // A fresh first beat counts before it reaches the pending count
      awvalid_r <= (!no_pending | burst_first) & !credit_empty;
    end else if (m_axi_awready) begin
      awvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      addr_r <= start_addr;
    end else if (aw_accept) begin
      addr_r <= addr_r + burst_bytes;
    end
  end

  a_aw_hold : assert property (
    @(posedge aclk) disable iff (areset)
    (m_axi_awvalid && !m_axi_awready) |=>
      m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen)
  );

endmodule

`default_nettype wire

/* hdl/write_data_channel.sv */
////////////////////////////////////////
// Stream to W channel gating
// Beat and burst counts, wlast, wstrb
////////////////////////////////////////
`default_nettype none

module write_data_channel import axi_write_pkg::*; #(
  parameter int log_burst_len = 4
) (
  input  logic                             aclk,
  input  logic                             areset,
  input  logic                             running,
  input  logic                             load,
  input  logic [beats_w-log_burst_len-1:0] num_bursts,
  input  logic [log_burst_len-1:0]         final_burst_len,
  input  logic [strb_w-1:0]                final_strb,
  input  logic                             s_axis_tvalid,
  output logic                             s_axis_tready,
  input  logic [data_w-1:0]                s_axis_tdata,
  output logic                             m_axi_wvalid,
  input  logic                             m_axi_wready,
  output logic [data_w-1:0]                m_axi_wdata,
  output logic [strb_w-1:0]                m_axi_wstrb,
  output logic                             m_axi_wlast,
  output logic                             burst_first,
  output logic                             beat_done
);

  localparam int nb_w = beats_w - log_burst_len;

  logic                     wxfer;
  logic                     burst_end;
  logic                     beat_zero;
  logic                     final_burst;
  logic                     next_is_final;
  logic [log_burst_len-1:0] beat_value;
  logic [nb_w-1:0]          bursts_left;
  logic                     wfirst;
  logic                     first_seen;

  // Straight pass-through, opened only while running
  assign m_axi_wvalid = s_axis_tvalid & running;
  assign s_axis_tready = m_axi_wready & running;
  assign m_axi_wdata = s_axis_tdata;
  assign wxfer = m_axi_wvalid & m_axi_wready;

  assign m_axi_wlast = beat_zero & s_axis_tvalid;
  assign burst_end = wxfer & m_axi_wlast;
  assign beat_done = burst_end & final_burst;
  // Short strobe only on the closing beat of the transfer
  assign m_axi_wstrb = (m_axi_wlast & final_burst) ? final_strb : '1;

  // Pick full or short length for the burst about to start
  assign next_is_final = load ? (num_bursts == '0) : (bursts_left == nb_w'(1));
  assign beat_value = next_is_final ? final_burst_len : '1;

  // Beats left in the current burst, zero on the last one
  up_down_counter #(
    .width (log_burst_len),
    .init  ('1)
  ) u_beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load | burst_end),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (beat_value),
    .count      (),
    .is_zero    (beat_zero)
  );

  // Bursts left after the current one
  up_down_counter #(
    .width (nb_w),
    .init  ('0)
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load),
    .incr       (1'b0),
    .decr       (burst_end & ~final_burst),
    .load_value (num_bursts),
    .count      (bursts_left),
    .is_zero    (final_burst)
  );

  ////////////////////////////////////////
  // First-beat detect for the AW side
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst <= 1'b1;
      first_seen <= 1'b0;
    end else begin
      if (wxfer) wfirst <= m_axi_wlast;
      // Remember a first beat already reported while it stalls
      first_seen <= wxfer ? 1'b0 : (first_seen | (m_axi_wvalid & wfirst));
    end
  end

  assign burst_first = m_axi_wvalid & wfirst & ~first_seen;

  // Beat counter sits at zero only inside a running transfer
  a_wlast_with_valid : assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_wlast |-> m_axi_wvalid
  );

endmodule

`default_nettype wire

/* hdl/write_response_channel.sv */
////////////////////////////////////////
// B channel, outstanding-burst credit
// and final response flag
////////////////////////////////////////
`default_nettype none

module write_response_channel import axi_write_pkg::*; #(
  parameter int max_outstanding = 4,
  parameter int log_burst_len = 4
) (
  input  logic                             aclk,
  input  logic                             areset,
  input  logic                             load,
  input  logic [beats_w-log_burst_len-1:0] num_bursts,
  input  logic                             aw_accept,
  input  logic                             m_axi_bvalid,
  output logic                             m_axi_bready,
  output logic                             credit_empty,
  output logic                             last_resp
);

  localparam int nb_w = beats_w - log_burst_len;
  localparam int cred_w = $clog2(max_outstanding + 1);

  logic resp_zero;

  // Responses are always taken
  assign m_axi_bready = 1'b1;
  assign last_resp = m_axi_bvalid & resp_zero;

  // Free slots, down on each address, up on each response
  up_down_counter #(
    .width (cred_w),
    .init  (cred_w'(max_outstanding))
  ) u_credit_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (m_axi_bvalid),
    .decr       (aw_accept),
    .load_value ('0),
    .count      (),
    .is_zero    (credit_empty)
  );

  // Responses still due after the next one
  up_down_counter #(
    .width (nb_w),
    .init  ('0)
  ) u_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load),
    .incr       (1'b0),
    .decr       (m_axi_bvalid & ~resp_zero),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (resp_zero)
  );

endmodule

`default_nettype wire

/* list.f */
+incdir+testbench
hdl/axi_write_pkg.sv
hdl/up_down_counter.sv
hdl/transfer_sequencer.sv
hdl/write_data_channel.sv
hdl/write_address_channel.sv
hdl/write_response_channel.sv
hdl/axi_stream_write_master.sv
testbench/tb_axi_stream_write_master.sv

/* testbench/tb_ref_model.svh */
////////////////////////////////////////
// Expected bursts, lengths, last strobe
// Stream source and AXI slave model
////////////////////////////////////////
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Stream beat n whose low half counts up
function automatic logic [data_w-1:0] beat_word(input int n);
  return {32'(n) ^ 32'h5a5a_0000, 32'(n)};
endfunction

// Burst list and final strobe for one request
function automatic void build_expected(input logic [addr_w-1:0] addr, input int bytes);
  int                beats;
  int                bursts;
  int                tail;
  logic [addr_w-1:0] span;
  beats = (bytes + 7) / 8;
  bursts = (beats + burst_len - 1) / burst_len;
  span = addr_w'(burst_len * 8);
  // Bytes on the last beat or a full beat when the size is a multiple of 8
  tail = (bytes % 8 == 0) ? 8 : bytes % 8;
  exp_addr.delete();
  exp_len.delete();
  for (int i = 0; i < bursts; i++) begin
    exp_addr.push_back(addr - (addr % span) + addr_w'(i) * span);
    // Full bursts first, leftover beats in the last one
    exp_len.push_back((i == bursts - 1) ? (beats - 1) % burst_len : burst_len - 1);
  end
  exp_beats = beats;
  for (int i = 0; i < strb_w; i++) begin
    exp_strb[i] = (i < tail);
  end
endfunction

// Random back-pressure on AW and W
task automatic step_ready_lines();
  m_axi_awready <= ($urandom_range(3) != 0);
  m_axi_wready <= ($urandom_range(3) != 0);
endtask

// Incrementing beats with random gaps
task automatic step_stream_source();
  int sent;
  sent = src_sent + ((s_axis_tvalid && s_axis_tready) ? 1 : 0);
  src_sent <= sent;
  // tvalid stays up until the beat is taken
  if (!s_axis_tvalid || s_axis_tready) begin
    if (sent < src_total && $urandom_range(3) != 0) begin
      s_axis_tvalid <= 1'b1;
      s_axis_tdata <= beat_word(sent);
    end else begin
      s_axis_tvalid <= 1'b0;
    end
  end
endtask

// One B per burst once its address and its wlast are both in
task automatic step_b_channel();
  int aw_n;
  int wl_n;
  aw_n = aw_got + ((m_axi_awvalid && m_axi_awready) ? 1 : 0);
  wl_n = wl_got + ((m_axi_wvalid && m_axi_wready && m_axi_wlast) ? 1 : 0);
  aw_got <= aw_n;
  wl_got <= wl_n;
  if (m_axi_bvalid) begin
    m_axi_bvalid <= 1'b0;
  end else if (!hold_resp && b_sent < aw_n && b_sent < wl_n) begin
    if (b_delay == 0) begin
      m_axi_bvalid <= 1'b1;
      b_sent <= b_sent + 1;
      b_delay <= $urandom_range(3);
    end else begin
      b_delay <= b_delay - 1;
    end
  end
endtask

`endif

/* testbench/tb_axi_stream_write_master.sv */
////////////////////////////////////////
// Testbench for the stream write master
// Clock, reset, tests, checking monitor
////////////////////////////////////////
`default_nettype none

module tb_axi_stream_write_master import axi_write_pkg::*; ();

  localparam int max_burst_len = 16;
  localparam int max_outstanding = 4;
  // 16 beats of 8 bytes stay well inside one 4 KiB page
  localparam int burst_len = max_burst_len;

  logic              aclk = 1'b0;
  logic              areset = 1'b1;
  logic              ctrl_start = 1'b0;
  logic              ctrl_done;
  logic [addr_w-1:0] ctrl_addr_offset = '0;
  logic [xfer_w-1:0] ctrl_xfer_size_in_bytes = '0;
  logic              m_axi_awvalid;
  logic              m_axi_awready = 1'b0;
  logic [addr_w-1:0] m_axi_awaddr;
  logic [7:0]        m_axi_awlen;
  logic              m_axi_wvalid;
  logic              m_axi_wready = 1'b0;
  logic [data_w-1:0] m_axi_wdata;
  logic [strb_w-1:0] m_axi_wstrb;
  logic              m_axi_wlast;
  logic              m_axi_bvalid = 1'b0;
  logic              m_axi_bready;
  logic              s_axis_tvalid = 1'b0;
  logic              s_axis_tready;
  logic [data_w-1:0] s_axis_tdata = '0;

  // Expected result of the current test
  logic [addr_w-1:0] exp_addr[$];
  int                exp_len[$];
  int                exp_beats = 0;
  logic [strb_w-1:0] exp_strb = '0;

  // Source and slave model state
  int src_total = 0;
  int src_sent = 0;
  int aw_got = 0;
  int wl_got = 0;
  int b_sent = 0;
  int b_delay = 0;
  bit hold_resp = 1'b0;

  // Monitor counts over the whole run
  int aw_total = 0;
  int w_total = 0;
  int b_total = 0;
  int first_total = 0;
  int done_total = 0;
  int mon_errors = 0;
  bit first_flag = 1'b0;
  bit b_final_prev = 1'b0;

  // Per-test snapshots and results
  int aw_base = 0;
  int w_base = 0;
  int b_base = 0;
  int done_base = 0;
  int err_base = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  always #4 aclk = ~aclk;

  axi_stream_write_master #(
    .max_burst_len   (max_burst_len),
    .max_outstanding (max_outstanding)
  ) dut (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_done               (ctrl_done),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .m_axi_awvalid           (m_axi_awvalid),
    .m_axi_awready           (m_axi_awready),
    .m_axi_awaddr            (m_axi_awaddr),
    .m_axi_awlen             (m_axi_awlen),
    .m_axi_wvalid            (m_axi_wvalid),
    .m_axi_wready            (m_axi_wready),
    .m_axi_wdata             (m_axi_wdata),
    .m_axi_wstrb             (m_axi_wstrb),
    .m_axi_wlast             (m_axi_wlast),
    .m_axi_bvalid            (m_axi_bvalid),
    .m_axi_bready            (m_axi_bready),
    .s_axis_tvalid           (s_axis_tvalid),
    .s_axis_tready           (s_axis_tready),
    .s_axis_tdata            (s_axis_tdata)
  );

  `include "tb_ref_model.svh"

  task automatic show_mismatch(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  always @(posedge aclk) begin
    step_ready_lines();
    step_stream_source();
    step_b_channel();
  end

  ////////////////////////////////////////
  // Monitor comparing every handshake
  ////////////////////////////////////////
  always @(posedge aclk) begin
    int k;
    bit b_hs;
    if (!areset) begin
      // AW against the burst list and never ahead of its first beat
      if (m_axi_awvalid && m_axi_awready) begin
        k = aw_total - aw_base;
        if (k >= exp_addr.size()) begin
          $display("Extra address handshake %0d at %0t", k, $time);
          mon_errors++;
        end else begin
          if (m_axi_awaddr !== exp_addr[k]) begin
            show_mismatch("m_axi_awaddr", m_axi_awaddr, exp_addr[k]);
            mon_errors++;
          end
          if (m_axi_awlen !== 8'(exp_len[k])) begin
            show_mismatch("m_axi_awlen", m_axi_awlen, exp_len[k]);
            mon_errors++;
          end
        end
        if (aw_total >= first_total) begin
          $display("Address of burst %0d accepted at %0t before its first beat", k, $time);
          mon_errors++;
        end
        aw_total++;
      end
      // First beat of a burst showing valid
      k = w_total - w_base;
      // Stream stays closed once every beat of the request is in
      if (k >= exp_beats && s_axis_tready) begin
        show_mismatch("s_axis_tready", s_axis_tready, 1'b0);
        mon_errors++;
      end
      if (m_axi_wvalid && !first_flag && k % burst_len == 0) begin
        first_total++;
        first_flag = 1'b1;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        if (k >= exp_beats) begin
          $display("Extra data beat %0d at %0t", k, $time);
          mon_errors++;
        end else begin
          if (m_axi_wdata !== beat_word(w_total)) begin
            show_mismatch("m_axi_wdata", m_axi_wdata, beat_word(w_total));
            mon_errors++;
          end
          if (m_axi_wlast !== (k % burst_len == exp_len[k / burst_len])) begin
            show_mismatch("m_axi_wlast", m_axi_wlast, !m_axi_wlast);
            mon_errors++;
          end
          if (m_axi_wstrb !== ((k == exp_beats - 1) ? exp_strb : {strb_w{1'b1}})) begin
            show_mismatch("m_axi_wstrb", m_axi_wstrb,
                          (k == exp_beats - 1) ? exp_strb : {strb_w{1'b1}});
            mon_errors++;
          end
        end
        first_flag = 1'b0;
        w_total++;
      end
      // Responses and the outstanding limit
      b_hs = m_axi_bvalid && m_axi_bready;
      if (m_axi_bvalid && !m_axi_bready) begin
        $display("bready low while bvalid is high at %0t", $time);
        mon_errors++;
      end
      if (b_hs) b_total++;
      if (aw_total - b_total > max_outstanding) begin
        $display("%0d bursts await a response at %0t, over the limit", aw_total - b_total,
                 $time);
        mon_errors++;
      end
      // Done must come one cycle after the final response
      if (ctrl_done) begin
        done_total++;
        if (!b_final_prev) begin
          $display("ctrl_done at %0t does not follow the final response", $time);
          mon_errors++;
        end
      end
      b_final_prev = b_hs && (b_total - b_base == exp_addr.size());
    end
  end

  ////////////////////////////////////////
  // One transfer with its end checks
  ////////////////////////////////////////
  task automatic run_test(input int id, input logic [addr_w-1:0] addr, input int bytes,
                          input bit hold, input bit restart);
    int cyc;
    int errs;
    @(negedge aclk);
    build_expected(addr, bytes);
    aw_base = aw_total;
    w_base = w_total;
    b_base = b_total;
    done_base = done_total;
    err_base = mon_errors + test_errors;
    src_total <= src_total + exp_beats;
    hold_resp <= hold;
    @(posedge aclk);
    ctrl_start <= 1'b1;
    ctrl_addr_offset <= addr;
    ctrl_xfer_size_in_bytes <= xfer_w'(bytes);
    @(posedge aclk);
    ctrl_start <= 1'b0;
    if (hold) begin
      // Credit runs out with every response held back
      for (cyc = 0; cyc < 2000 && aw_total - aw_base < max_outstanding; cyc++) @(negedge aclk);
      if (aw_total - aw_base < max_outstanding) begin
        $display("test %0d: address count never reached the credit limit", id);
        test_errors++;
      end
      repeat (20) @(negedge aclk);
      if (aw_total - aw_base != max_outstanding) begin
        show_mismatch("m_axi_awvalid handshakes", aw_total - aw_base, max_outstanding);
        test_errors++;
      end
      hold_resp <= 1'b0;
    end
    if (restart) begin
      // A second start while busy is dropped
      repeat (3) @(posedge aclk);
      ctrl_start <= 1'b1;
      ctrl_addr_offset <= addr + 32'h1000;
      @(posedge aclk);
      ctrl_start <= 1'b0;
    end
    for (cyc = 0; cyc < 5000 && done_total == done_base; cyc++) @(negedge aclk);
    if (done_total == done_base) begin
      $display("test %0d: timed out waiting for ctrl_done", id);
      $display("*** FAILED ***");
      $finish;
    end else begin
      repeat (8) @(negedge aclk);
      if (aw_total - aw_base != exp_addr.size()) begin
        show_mismatch("m_axi_awvalid handshakes", aw_total - aw_base, exp_addr.size());
        test_errors++;
      end
      if (w_total - w_base != exp_beats) begin
        show_mismatch("m_axi_wvalid handshakes", w_total - w_base, exp_beats);
        test_errors++;
      end
      if (b_total - b_base != exp_addr.size()) begin
        show_mismatch("m_axi_bvalid handshakes", b_total - b_base, exp_addr.size());
        test_errors++;
      end
      if (done_total - done_base != 1) begin
        show_mismatch("ctrl_done pulses", done_total - done_base, 1);
        test_errors++;
      end
      errs = mon_errors + test_errors - err_base;
      tests_run++;
      if (errs != 0) tests_failed++;
      $display("test %0d: addr %h, %0d bytes, %0d bursts: %s", id, addr, bytes,
               exp_addr.size(), (errs == 0) ? "ok" : "failed");
    end
  endtask

  initial begin
    void'($urandom(32'h6474));
    repeat (2) @(posedge aclk);
    areset <= 1'b0;
    repeat (2) @(posedge aclk);
    run_test(1, 32'h0000_1000, 1024, 1'b0, 1'b0);
    run_test(2, 32'h0000_2345, 300, 1'b0, 1'b0);
    run_test(3, 32'h0001_0007, 5, 1'b0, 1'b0);
    run_test(4, 32'h0000_8000, 2051, 1'b1, 1'b0);
    run_test(5, 32'h0004_0080, 1000, 1'b0, 1'b1);
    for (int i = 6; i < 12; i++) begin
      run_test(i, $urandom, $urandom_range(3000, 1), 1'b0, 1'b0);
    end
    $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
             mon_errors + test_errors);
    if (tests_failed == 0 && mon_errors + test_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
